/* include/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Data path and address width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// Program counter value seen by the stage register after reset
`define RESET_PC 32'h0000_0000

`endif

/* src/id_pkg.sv */
`include "id_settings.svh"

package id_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_IMM    = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_REG    = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [2:0] {
        LD_NONE, LD_B, LD_H, LD_W, LD_BU, LD_HU
    } load_op_e;

    typedef enum logic [1:0] {
        ST_NONE, ST_B, ST_H, ST_W
    } store_op_e;

    // Source of the second ALU operand
    typedef enum logic [1:0] {
        ORIG_RS2, ORIG_IMM, ORIG_PC, ORIG_PC4
    } origin_e;

    typedef struct packed {
        alu_op_e                alu_op;
        load_op_e               load_op;
        store_op_e              store_op;
        origin_e                origin;
        logic                   regfile_wr;
        logic [`REG_ADDR_W-1:0] waddr;
        logic                   is_load_store;
        logic                   data_wr;
        logic                   data_rd;
        logic [3:0]             data_be;
        logic [`XLEN-1:0]       imm;
    } ex_ctrl_t;

    typedef struct packed {
        logic                   wr;
        logic                   is_load;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       data;
    } mem_fwd_t;

    typedef struct packed {
        logic                   wr;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage

/* src/id_decoder.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module id_decoder import id_pkg::*;
(
    input  logic [`XLEN-1:0]       instr_i,
    output ex_ctrl_t               ctrl_o,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    output logic                   uses_rs1_o,
    output logic                   uses_rs2_o,
    output br_op_e                 br_op_o,
    output logic                   origin_pc_o
);

    logic [2:0] funct3;
    logic       alt;        // Bit 30 selects SUB and SRA
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // ALU operation from funct3, sub_sra picks SUB or SRA where allowed
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic sub_sra);
        alu_op_e op;
        case (f3)
            3'd0:    op = sub_sra ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = sub_sra ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl_o      = '0;
        br_op_o     = BR_NONE;
        origin_pc_o = 1'b0;
        uses_rs1_o  = 1'b0;
        uses_rs2_o  = 1'b0;
        rs1_addr_o  = instr_i[19:15];
        rs2_addr_o  = instr_i[24:20];

        case (opcode_e'(instr_i[6:0]))
            OPC_REG:
            begin
                ctrl_o.alu_op     = alu_from_funct3(funct3, alt);
                ctrl_o.origin     = ORIG_RS2;
                ctrl_o.regfile_wr = 1'b1;
                uses_rs1_o        = 1'b1;
                uses_rs2_o        = 1'b1;
            end
            OPC_IMM:
            begin
                ctrl_o.alu_op     = alu_from_funct3(funct3, alt && funct3 == 3'd5); // No SUBI
                ctrl_o.origin     = ORIG_IMM;
                ctrl_o.regfile_wr = 1'b1;
                ctrl_o.imm        = imm_i;
                uses_rs1_o        = 1'b1;
            end
            OPC_LUI:
            begin
                rs1_addr_o        = '0;  // Zero plus immediate
                ctrl_o.origin     = ORIG_IMM;
                ctrl_o.regfile_wr = 1'b1;
                ctrl_o.imm        = imm_u;
            end
            OPC_AUIPC:
            begin
                ctrl_o.origin     = ORIG_PC;
                ctrl_o.regfile_wr = 1'b1;
                ctrl_o.imm        = imm_u;
                origin_pc_o       = 1'b1;
            end
            OPC_LOAD:
            begin
                case (funct3)
                    3'd0:    ctrl_o.load_op = LD_B;
                    3'd1:    ctrl_o.load_op = LD_H;
                    3'd2:    ctrl_o.load_op = LD_W;
                    3'd4:    ctrl_o.load_op = LD_BU;
                    3'd5:    ctrl_o.load_op = LD_HU;
                    default: ctrl_o.load_op = LD_NONE;
                endcase
                ctrl_o.origin        = ORIG_IMM;
                ctrl_o.regfile_wr    = 1'b1;
                ctrl_o.is_load_store = 1'b1;
                ctrl_o.data_rd       = 1'b1;
                ctrl_o.imm           = imm_i;
                uses_rs1_o           = 1'b1;
            end
            OPC_STORE:
            begin
                case (funct3)
                    3'd0:    ctrl_o.store_op = ST_B;
                    3'd1:    ctrl_o.store_op = ST_H;
                    3'd2:    ctrl_o.store_op = ST_W;
                    default: ctrl_o.store_op = ST_NONE;
                endcase
                case (funct3)
                    3'd0:    ctrl_o.data_be = 4'b0001;
                    3'd1:    ctrl_o.data_be = 4'b0011;
                    3'd2:    ctrl_o.data_be = 4'b1111;
                    default: ctrl_o.data_be = 4'b0000;
                endcase
                ctrl_o.origin        = ORIG_IMM;
                ctrl_o.is_load_store = 1'b1;
                ctrl_o.data_wr       = 1'b1;
                ctrl_o.imm           = imm_s;
                uses_rs1_o           = 1'b1;
                uses_rs2_o           = 1'b1;
            end
            OPC_BRANCH:
            begin
                case (funct3)
                    3'd0:    br_op_o = BR_EQ;
                    3'd1:    br_op_o = BR_NE;
                    3'd4:    br_op_o = BR_LT;
                    3'd5:    br_op_o = BR_GE;
                    3'd6:    br_op_o = BR_LTU;
                    3'd7:    br_op_o = BR_GEU;
                    default: br_op_o = BR_NONE;
                endcase
                ctrl_o.imm = imm_b;
                uses_rs1_o = 1'b1;
                uses_rs2_o = 1'b1;
            end
            OPC_JAL:
            begin
                br_op_o           = BR_JAL;
                ctrl_o.origin     = ORIG_PC4;  // Link value
                ctrl_o.regfile_wr = 1'b1;
                ctrl_o.imm        = imm_j;
            end
            OPC_JALR:
            begin
                br_op_o           = BR_JALR;
                ctrl_o.origin     = ORIG_PC4;
                ctrl_o.regfile_wr = 1'b1;
                ctrl_o.imm        = imm_i;
                uses_rs1_o        = 1'b1;
            end
            default:
            begin
                ctrl_o = '0;  // Unknown opcode acts as a bubble
            end
        endcase

        // Destination only meaningful when the register file is written
        ctrl_o.waddr = ctrl_o.regfile_wr ? instr_i[11:7] : '0;
    end

endmodule

/* src/int_reg_file.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module int_reg_file import id_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  wb_t                    wb_i,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o
);

    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_i.wr && wb_i.waddr != '0)
        begin
            regs[wb_i.waddr] <= wb_i.data;
        end
    end

    // Reads see the value before a same-cycle write
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* src/operand_fwd.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module operand_fwd import id_pkg::*;
(
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                   uses_rs1_i,
    input  logic                   uses_rs2_i,
    input  logic [`XLEN-1:0]       rf_rs1_i,
    input  logic [`XLEN-1:0]       rf_rs2_i,
    input  ex_ctrl_t               e_ctrl_i,
    input  logic [`XLEN-1:0]       alu_i,
    input  mem_fwd_t               m_fwd_i,
    input  wb_t                    w_wb_i,
    output logic [`XLEN-1:0]       rs1_o,
    output logic [`XLEN-1:0]       rs2_o,
    output logic                   stall_o
);

    // Newest producer wins, loads in flight are not forwarded
    function automatic logic [`XLEN-1:0] pick(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rf_data,
        input ex_ctrl_t               ex,
        input logic [`XLEN-1:0]       alu,
        input mem_fwd_t               mem,
        input wb_t                    wb
    );
        logic [`XLEN-1:0] val;
        if (addr == '0)
            val = '0;
        else if (ex.regfile_wr && ex.waddr == addr && !ex.data_rd)
            val = alu;
        else if (mem.wr && mem.waddr == addr && !mem.is_load)
            val = mem.data;
        else if (wb.wr && wb.waddr == addr)
            val = wb.data;  // Covers the same-cycle register file write
        else
            val = rf_data;
        return val;
    endfunction

    // A used source waiting on a load result
    function automatic logic load_hit(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic                   used,
        input ex_ctrl_t               ex,
        input mem_fwd_t               mem
    );
        logic ex_hit;
        logic mem_hit;
        ex_hit  = ex.data_rd && ex.waddr == addr;
        mem_hit = mem.is_load && mem.waddr == addr;
        return used && addr != '0 && (ex_hit || mem_hit);
    endfunction

    assign rs1_o = pick(rs1_addr_i, rf_rs1_i, e_ctrl_i, alu_i, m_fwd_i, w_wb_i);
    assign rs2_o = pick(rs2_addr_i, rf_rs2_i, e_ctrl_i, alu_i, m_fwd_i, w_wb_i);

    assign stall_o = load_hit(rs1_addr_i, uses_rs1_i, e_ctrl_i, m_fwd_i)
                  || load_hit(rs2_addr_i, uses_rs2_i, e_ctrl_i, m_fwd_i);

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module branch_unit import id_pkg::*;
(
    input  br_op_e           br_op_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] imm_i,
    input  logic [`XLEN-1:0] rs1_i,
    input  logic [`XLEN-1:0] rs2_i,
    output logic             taken_o,
    output logic [`XLEN-1:0] target_o
);

    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic [`XLEN-1:0] jalr_sum;

    assign eq   = (rs1_i == rs2_i);
    assign lt_s = ($signed(rs1_i) < $signed(rs2_i));
    assign lt_u = (rs1_i < rs2_i);

    always_comb
    begin
        case (br_op_i)
            BR_EQ:   taken_o = eq;
            BR_NE:   taken_o = !eq;
            BR_LT:   taken_o = lt_s;
            BR_GE:   taken_o = !lt_s;
            BR_LTU:  taken_o = lt_u;
            BR_GEU:  taken_o = !lt_u;
            BR_JAL,
            BR_JALR: taken_o = 1'b1;  // Jumps always redirect
            default: taken_o = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_i + imm_i;

    // JALR target has its low bit cleared
    assign target_o = (br_op_i == BR_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                           : pc_i + imm_i;

endmodule

/* src/id_stage.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module id_stage import id_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] d_instr_i,
    input  logic [`XLEN-1:0] d_pc_i,
    input  logic [`XLEN-1:0] d_pc4_i,
    input  logic [`XLEN-1:0] alu_i,       // Execute result of the instruction in e_ctrl_o
    input  mem_fwd_t         m_fwd_i,
    input  wb_t              w_wb_i,
    input  logic             busy_i,      // Multi-cycle ALU still working
    output ex_ctrl_t         e_ctrl_o,
    output logic [`XLEN-1:0] e_rs1_o,
    output logic [`XLEN-1:0] e_rs2_o,
    output logic [`XLEN-1:0] e_pc4_o,
    output logic [`XLEN-1:0] e_brj_pc_o,
    output logic             stall_o,
    output logic             brj_o,
    output logic [`XLEN-1:0] brj_pc_o
);

    ex_ctrl_t               dec_ctrl;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic                   uses_rs1;
    logic                   uses_rs2;
    br_op_e                 br_op;
    logic                   origin_pc;
    logic [`XLEN-1:0]       rf_rs1;
    logic [`XLEN-1:0]       rf_rs2;
    logic [`XLEN-1:0]       fwd_rs1;
    logic [`XLEN-1:0]       fwd_rs2;

    id_decoder id_decoder_i (
        .instr_i     (d_instr_i),
        .ctrl_o      (dec_ctrl),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .uses_rs1_o  (uses_rs1),
        .uses_rs2_o  (uses_rs2),
        .br_op_o     (br_op),
        .origin_pc_o (origin_pc)
    );

    int_reg_file int_reg_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_i       (w_wb_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    operand_fwd operand_fwd_i (
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .uses_rs1_i (uses_rs1),
        .uses_rs2_i (uses_rs2),
        .rf_rs1_i   (rf_rs1),
        .rf_rs2_i   (rf_rs2),
        .e_ctrl_i   (e_ctrl_o),   // Execute bypass from our own stage register
        .alu_i      (alu_i),
        .m_fwd_i    (m_fwd_i),
        .w_wb_i     (w_wb_i),
        .rs1_o      (fwd_rs1),
        .rs2_o      (fwd_rs2),
        .stall_o    (stall_o)
    );

    branch_unit branch_unit_i (
        .br_op_i  (br_op),
        .pc_i     (d_pc_i),
        .imm_i    (dec_ctrl.imm),
        .rs1_i    (fwd_rs1),
        .rs2_i    (fwd_rs2),
        .taken_o  (brj_o),
        .target_o (brj_pc_o)
    );

    // Decode to execute register, frozen while the ALU is busy
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            e_ctrl_o   <= '0;
            e_rs1_o    <= '0;
            e_rs2_o    <= '0;
            e_pc4_o    <= `RESET_PC;
            e_brj_pc_o <= `RESET_PC;
        end
        else if (!busy_i)
        begin
            e_ctrl_o   <= dec_ctrl;
            e_rs1_o    <= origin_pc ? d_pc_i : fwd_rs1;  // AUIPC adds to the PC
            e_rs2_o    <= fwd_rs2;
            e_pc4_o    <= d_pc4_i;
            e_brj_pc_o <= brj_pc_o;
        end
    end

endmodule

/* tb/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*;
();

    localparam int MAX_REC      = 64;
    localparam int NUM_COLS     = 29;
    localparam int RESET_CYCLES = 5;

    logic        clk;
    logic        rst_n;
    logic [31:0] d_instr_i;
    logic [31:0] d_pc_i;
    logic [31:0] d_pc4_i;
    logic [31:0] alu_i;
    mem_fwd_t    m_fwd_i;
    wb_t         w_wb_i;
    logic        busy_i;
    ex_ctrl_t    e_ctrl_o;
    logic [31:0] e_rs1_o;
    logic [31:0] e_rs2_o;
    logic [31:0] e_pc4_o;
    logic [31:0] e_brj_pc_o;
    logic        stall_o;
    logic        brj_o;
    logic [31:0] brj_pc_o;

    logic [31:0] col [MAX_REC][NUM_COLS];  // One row per stimulus record
    int          num_rec     = 0;
    bit          file_ok     = 1'b1;
    int          cur_test    = 0;
    int          test_errors = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycles      = 0;
    int          limit       = MAX_REC + RESET_CYCLES + 20;

    id_stage id_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .d_instr_i  (d_instr_i),
        .d_pc_i     (d_pc_i),
        .d_pc4_i    (d_pc4_i),
        .alu_i      (alu_i),
        .m_fwd_i    (m_fwd_i),
        .w_wb_i     (w_wb_i),
        .busy_i     (busy_i),
        .e_ctrl_o   (e_ctrl_o),
        .e_rs1_o    (e_rs1_o),
        .e_rs2_o    (e_rs2_o),
        .e_pc4_o    (e_pc4_o),
        .e_brj_pc_o (e_brj_pc_o),
        .stall_o    (stall_o),
        .brj_o      (brj_o),
        .brj_pc_o   (brj_pc_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Ends a run that stops making progress
    initial
    begin
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles > limit)
            begin
                $display("Timeout: run did not finish within %0d cycles", limit);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v [NUM_COLS];
        fd = $fopen("tb/id_stage_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file tb/id_stage_stimulus.txt");
            file_ok = 1'b0;
            return;
        end
        while (!$feof(fd) && num_rec < MAX_REC)
        begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;  // Blank or column description
            n = $sscanf(line,
                        "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                        v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16],
                        v[17], v[18], v[19], v[20], v[21], v[22], v[23], v[24], v[25],
                        v[26], v[27], v[28]);
            if (n != NUM_COLS)
            begin
                $display("Stimulus line has the wrong number of fields: %s", line);
                file_ok = 1'b0;
            end
            else
            begin
                for (int k = 0; k < NUM_COLS; k++)
                begin
                    col[num_rec][k] = v[k];
                end
                num_rec++;
            end
        end
        $fclose(fd);
        if (num_rec == 0)
        begin
            $display("The stimulus file holds no records");
            file_ok = 1'b0;
        end
    endtask

    task automatic check_value(string field, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR at %0t ns: test %0d, %s is %h, expected %h",
                     $time, cur_test, field, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0)
        begin
            pass_count++;
            $display("Test %0d passed", cur_test);
        end
        else
        begin
            fail_count++;
            $display("Test %0d failed with %0d mismatches", cur_test, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic drive_record(int i);
        d_instr_i       = col[i][1];
        d_pc_i          = col[i][2];
        d_pc4_i         = col[i][3];
        alu_i           = col[i][4];
        m_fwd_i.wr      = col[i][5][0];
        m_fwd_i.is_load = col[i][6][0];
        m_fwd_i.waddr   = col[i][7][4:0];
        m_fwd_i.data    = col[i][8];
        w_wb_i.wr       = col[i][9][0];
        w_wb_i.waddr    = col[i][10][4:0];
        w_wb_i.data     = col[i][11];
        busy_i          = col[i][12][0];
    endtask

    task automatic check_regs(int i);
        check_value("alu_op", e_ctrl_o.alu_op, col[i][16]);
        check_value("load_op", e_ctrl_o.load_op, col[i][17]);
        check_value("store_op", e_ctrl_o.store_op, col[i][18]);
        check_value("origin", e_ctrl_o.origin, col[i][19]);
        check_value("regfile_wr", e_ctrl_o.regfile_wr, col[i][20]);
        check_value("waddr", e_ctrl_o.waddr, col[i][21]);
        check_value("ls_rd_wr",
                    {e_ctrl_o.is_load_store, e_ctrl_o.data_rd, e_ctrl_o.data_wr},
                    col[i][22]);
        check_value("data_be", e_ctrl_o.data_be, col[i][23]);
        check_value("imm", e_ctrl_o.imm, col[i][24]);
        check_value("e_rs1_o", e_rs1_o, col[i][25]);
        check_value("e_rs2_o", e_rs2_o, col[i][26]);
        check_value("e_pc4_o", e_pc4_o, col[i][27]);
        check_value("e_brj_pc_o", e_brj_pc_o, col[i][28]);
    endtask

    initial
    begin
        rst_n     = 1'b0;
        d_instr_i = '0;
        d_pc_i    = '0;
        d_pc4_i   = '0;
        alu_i     = '0;
        m_fwd_i   = '0;
        w_wb_i    = '0;
        busy_i    = 1'b0;
        load_stimulus();
        limit = num_rec + RESET_CYCLES + 20;

        // Test 0 is the reset state
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            #1;
            check_value("e_ctrl_o", e_ctrl_o[31:0], 32'h0);
            check_value("e_ctrl_o upper", e_ctrl_o[55:32], 32'h0);
            check_value("regfile_wr", e_ctrl_o.regfile_wr, 32'h0);
            check_value("e_rs1_o", e_rs1_o, 32'h0);
            check_value("e_rs2_o", e_rs2_o, 32'h0);
            check_value("e_pc4_o", e_pc4_o, 32'h0);
            check_value("e_brj_pc_o", e_brj_pc_o, 32'h0);
        end
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < num_rec; i++)
        begin
            if (col[i][0] != cur_test)
            begin
                finish_test();
                cur_test = col[i][0];
            end
            @(negedge clk);
            drive_record(i);
            #19;  // Just before the rising edge
            check_value("stall_o", stall_o, col[i][13]);
            check_value("brj_o", brj_o, col[i][14]);
            check_value("brj_pc_o", brj_pc_o, col[i][15]);
            @(posedge clk);
            #1;
            check_regs(i);
        end
        finish_test();

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && file_ok)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/id_stage_stimulus.txt */
# test instr pc pc4 alu m_wr m_ld m_addr m_data w_wr w_addr w_data busy | stall brj brj_pc
# | alu_op ld st orig rwr waddr ls_rd_wr be imm e_rs1 e_rs2 e_pc4 e_brj_pc   (all hex)
1 00000000 0 0 0 0 0 0 0 1 01 00000010 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0
1 00000000 0 0 0 0 0 0 0 1 02 fffffff0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0
1 00000000 0 0 0 0 0 0 0 1 03 00000005 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0
1 00000000 0 0 0 0 0 0 0 1 04 80000000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0
1 00000000 0 0 0 0 0 0 0 1 05 00001001 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0
2 00208533 100 104 0 0 0 0 0 0 0 0 0 0 0 100 0 0 0 0 1 0a 0 0 0 10 fffffff0 104 100
2 ffd08593 108 10c 0 0 0 0 0 0 0 0 0 0 0 105 0 0 0 1 1 0b 0 0 fffffffd 10 0 10c 105
2 12345637 10c 110 0 0 0 0 0 0 0 0 0 0 0 1234510c 0 0 0 1 1 0c 0 0 12345000 0 5 110 1234510c
2 00001697 110 114 0 0 0 0 0 0 0 0 0 0 0 1110 0 0 0 2 1 0d 0 0 1000 110 0 114 1110
2 0080a703 114 118 0 0 0 0 0 0 0 0 0 0 0 11c 0 3 0 1 1 0e 6 0 8 10 0 118 11c
2 003102a3 118 11c 0 0 0 0 0 0 0 0 0 0 0 11d 0 0 1 1 0 00 5 1 5 fffffff0 5 11c 11d
3 002083b3 200 204 0 0 0 0 0 0 0 0 0 0 0 200 0 0 0 0 1 07 0 0 0 10 fffffff0 204 200
3 00738433 204 208 aaaa0001 1 0 07 bbbb0002 1 07 cccc0003 0 0 0 204 0 0 0 0 1 08 0 0 0 aaaa0001 aaaa0001 208 204
3 007384b3 208 20c aaaa0001 1 0 07 bbbb0002 1 07 cccc0005 0 0 0 208 0 0 0 0 1 09 0 0 0 bbbb0002 bbbb0002 20c 208
3 00738533 20c 210 aaaa0001 0 0 0 0 1 07 dddd0004 0 0 0 20c 0 0 0 0 1 0a 0 0 0 dddd0004 dddd0004 210 20c
3 007385b3 210 214 0 0 0 0 0 0 0 0 0 0 0 210 0 0 0 0 1 0b 0 0 0 dddd0004 dddd0004 214 210
3 00000633 214 218 1 1 0 00 11111111 1 00 22222222 0 0 0 214 0 0 0 0 1 0c 0 0 0 0 0 218 214
3 0000a783 218 21c 0 0 0 0 0 0 0 0 0 0 0 218 0 3 0 1 1 0f 6 0 0 10 0 21c 218
3 003784b3 21c 220 eeee0000 0 0 0 0 0 0 0 0 1 0 21c 0 0 0 0 1 09 0 0 0 0 5 220 21c
4 003086b3 300 304 0 1 1 03 99 0 0 0 0 1 0 300 0 0 0 0 1 0d 0 0 0 10 5 304 300
4 00308713 304 308 0 1 1 03 99 0 0 0 0 0 0 307 0 0 0 1 1 0e 0 0 3 10 5 308 307
4 00000633 308 30c 0 1 1 00 99 0 0 0 0 0 0 308 0 0 0 0 1 0c 0 0 0 0 0 30c 308
4 0000a783 30c 310 0 0 0 0 0 0 0 0 0 0 0 30c 0 3 0 1 1 0f 6 0 0 10 0 310 30c
4 003784b3 310 314 0 0 0 0 0 0 0 0 0 1 0 310 0 0 0 0 1 09 0 0 0 0 5 314 310
5 00108863 400 404 0 0 0 0 0 0 0 0 0 0 1 410 0 0 0 0 0 00 0 0 10 10 10 404 410
5 fe209ce3 404 408 0 0 0 0 0 0 0 0 0 0 1 3fc 0 0 0 0 0 00 0 0 fffffff8 10 fffffff0 408 3fc
5 00114863 408 40c 0 0 0 0 0 0 0 0 0 0 1 418 0 0 0 0 0 00 0 0 10 fffffff0 10 40c 418
5 00116863 40c 410 0 0 0 0 0 0 0 0 0 0 0 41c 0 0 0 0 0 00 0 0 10 fffffff0 10 410 41c
5 0041e863 410 414 0 0 0 0 0 0 0 0 0 0 1 420 0 0 0 0 0 00 0 0 10 5 80000000 414 420
5 10000a6f 414 418 0 0 0 0 0 0 0 0 0 0 1 514 0 0 0 3 1 14 0 0 100 0 0 418 514
5 00428ae7 418 41c 0 0 0 0 0 0 0 0 0 0 1 1004 0 0 0 3 1 15 0 0 4 1001 80000000 41c 1004
6 ffd08593 500 504 0 0 0 0 0 0 0 0 0 0 0 4fd 0 0 0 1 1 0b 0 0 fffffffd 10 0 504 4fd
6 00208533 504 508 0 0 0 0 0 0 0 0 1 0 0 504 0 0 0 1 1 0b 0 0 fffffffd 10 0 504 4fd
6 12345637 508 50c 0 0 0 0 0 0 0 0 1 0 0 12345508 0 0 0 1 1 0b 0 0 fffffffd 10 0 504 4fd
6 00208533 50c 510 0 0 0 0 0 0 0 0 0 0 0 50c 0 0 0 0 1 0a 0 0 0 10 fffffff0 510 50c

/* verilog.f */
+incdir+include
src/id_pkg.sv
src/id_decoder.sv
src/int_reg_file.sv
src/operand_fwd.sv
src/branch_unit.sv
src/id_stage.sv
tb/tb_id_stage.sv
